/* filelist.f */
design/box_pkg.sv
design/window_ctrl.sv
design/col_adder_tree.sv
design/box_accum.sv
design/threshold_cmp.sv
design/box_thresh_top.sv
tests/box_thresh_assert.sv
tests/box_thresh_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module box_thresh_tb &&
  ./obj_dir/Vbox_thresh_tb | tee /dev/stderr | grep -qx "Regression passed" &&
  echo "run.sh: simulation ok" ||
  { echo "run.sh: simulation did not pass"; exit 1; }

/* tests/box_thresh_tb.sv */
`timescale 1ns/1ps

module box_thresh_tb;

  import box_pkg::*;

  localparam int NUM_TESTS = 11;
  localparam int LATENCY   = 7;

  typedef enum int {PIX_CONST, PIX_RAMP, PIX_RAND} pix_mode_t;

  typedef struct {
    string     name;
    int        ncols;
    int        gap;       // idle cycles after each strobe.
    bit        gap_rand;  // each gap is drawn from 0..gap.
    pix_mode_t mode;
    int        value;
    int        offset;
    int        n_out;     // outputs the row must produce.
  } test_t;

  typedef struct packed {
    int sum;
    int center;
    int bin;
    int cycle;
  } expect_t;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     i_col_valid;
  logic     i_row_start;
  column_t  i_column;
  pixel_t   i_offset;
  logic     o_valid;
  logic     o_bin;
  box_sum_t o_box_sum;
  pixel_t   o_center;

  test_t   tests [NUM_TESTS];
  expect_t exp_q [$];
  column_t row_cols [$];  // every column of the row being played.
  int cycle = 0;
  int cycle_limit;
  int errors = 0;
  int n_seen = 0;
  int cur = 0;
  int n_pass = 0;
  int n_fail = 0;

  box_thresh_top i_box_thresh_top (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("timeout after %0d cycles with %0d expected outputs still pending",
               cycle, exp_q.size());
      $display("Regression failed");
      $finish;
    end
  end

  // ##############################
  // checks and reference model
  // ##############################

  task automatic check_value(string what, int expected, int actual);
    if (expected != actual) begin
      $display("ERROR %s %s: expected %0d, actual %0d", tests[cur].name, what, expected, actual);
      errors++;
    end
  endtask

  function automatic pixel_t pixel_value(test_t t, int col, int row);
    case (t.mode)
      PIX_CONST: return pixel_t'(t.value);
      PIX_RAMP:  return pixel_t'(t.value + 11 * col + 3 * row);  // wraps past 255.
      default:   return pixel_t'($urandom);
    endcase
  endfunction

  task automatic model_column(int j, int offset, int strobe_cycle);
    expect_t e;
    if (j >= 12) begin
      e.sum = 0;
      for (int c = j - 12; c <= j; c++) begin
        for (int r = 0; r < 13; r++) begin
          e.sum += int'(row_cols[c][r]);
        end
      end
      e.center = int'(row_cols[j-6][6]);
      // an integer beats the mean exactly when it beats the mean rounded down.
      e.bin = (e.center - offset > e.sum / 169) ? 1 : 0;
      e.cycle = strobe_cycle;
      exp_q.push_back(e);
    end
  endtask

  always @(negedge clk) begin
    expect_t e;
    if (rst_n && o_valid) begin
      n_seen++;
      if (exp_q.size() == 0) begin
        $display("unexpected o_valid in test %s with no output pending", tests[cur].name);
        errors++;
      end else begin
        e = exp_q.pop_front();
        check_value("box sum", e.sum, int'(o_box_sum));
        check_value("center", e.center, int'(o_center));
        check_value("bin", e.bin, int'(o_bin));
        check_value("latency", LATENCY, cycle - e.cycle);
      end
    end
  end

  // ##############################
  // stimulus
  // ##############################

  task automatic set_test(int i, string name, int ncols, int gap, bit gap_rand,
                          pix_mode_t mode, int value, int offset, int n_out);
    tests[i] = '{name, ncols, gap, gap_rand, mode, value, offset, n_out};
  endtask

  function automatic int run_limit();
    int cols = 0;
    int gmax = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      cols += tests[i].ncols;
      if (tests[i].gap > gmax) gmax = tests[i].gap;
    end
    return cols * (gmax + 1) + LATENCY * NUM_TESTS + 50;
  endfunction

  task automatic play_row(int t);
    column_t col;
    int      gap;
    row_cols.delete();
    i_offset = pixel_t'(tests[t].offset);
    for (int j = 0; j < tests[t].ncols; j++) begin
      for (int r = 0; r < WIN; r++) col[r] = pixel_value(tests[t], j, r);
      row_cols.push_back(col);
      i_col_valid = 1'b1;
      i_row_start = (j == 0);
      i_column    = col;
      model_column(j, tests[t].offset, cycle);
      @(posedge clk);
      #1;
      i_col_valid = 1'b0;
      i_row_start = 1'b0;
      gap = tests[t].gap_rand ? $urandom_range(tests[t].gap, 0) : tests[t].gap;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  initial begin
    int err_before;
    void'($urandom(33));
    set_test(0,  "short_row",    8,  0, 1'b0, PIX_CONST, 100, 0,   0);
    set_test(1,  "exact_window", 13, 0, 1'b0, PIX_CONST, 200, 0,   1);
    set_test(2,  "const_max",    20, 0, 1'b0, PIX_CONST, 255, 0,   8);
    set_test(3,  "const_zero",   14, 0, 1'b0, PIX_CONST, 0,   0,   2);
    set_test(4,  "random_long",  60, 0, 1'b0, PIX_RAND,  0,   8,   48);
    set_test(5,  "new_row",      30, 0, 1'b0, PIX_RAND,  0,   0,   18);
    set_test(6,  "random_gaps",  40, 3, 1'b1, PIX_RAND,  0,   4,   28);
    set_test(7,  "ramp_off0",    25, 0, 1'b0, PIX_RAMP,  5,   0,   13);
    set_test(8,  "ramp_off10",   25, 0, 1'b0, PIX_RAMP,  5,   10,  13);
    set_test(9,  "ramp_off255",  25, 0, 1'b0, PIX_RAMP,  5,   255, 13);
    set_test(10, "fixed_gap",    20, 2, 1'b0, PIX_RAND,  0,   20,  8);
    cycle_limit = run_limit();

    rst_n       = 1'b0;
    i_col_valid = 1'b0;
    i_row_start = 1'b0;
    i_column    = '0;
    i_offset    = '0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    for (int t = 0; t < NUM_TESTS; t++) begin
      cur        = t;
      err_before = errors;
      n_seen     = 0;
      play_row(t);
      while (exp_q.size() != 0) @(negedge clk);  // the watchdog bounds this wait.
      @(posedge clk);
      #1;
      check_value("output count", tests[t].n_out, n_seen);
      if (errors == err_before) n_pass++;
      else n_fail++;
      $display("%-14s %s  outputs %0d", tests[t].name, (errors == err_before) ? "ok" : "FAILED",
               n_seen);
    end

    repeat (LATENCY + 1) @(negedge clk);
    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* tests/box_thresh_assert.sv */
`timescale 1ns/1ps

module box_thresh_assert (
  input logic clk,
  input logic rst_n,
  input logic i_col_valid,
  input logic i_row_start,
  input logic o_valid
);

  // the output register clears on the reset edge.
  a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !o_valid)
    else $error("o_valid high during reset or in the cycle after it");

  a_valid_source: assert property (@(posedge clk) disable iff (!rst_n)
    o_valid && $past(o_valid) |-> $past(i_col_valid, 7) && $past(i_col_valid, 8))
    else $error("o_valid held two cycles without strobes seven cycles earlier");

  a_row_start: assert property (@(posedge clk) i_row_start |-> i_col_valid)
    else $error("i_row_start without i_col_valid");

endmodule

bind box_thresh_top box_thresh_assert i_box_thresh_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .i_col_valid (i_col_valid),
  .i_row_start (i_row_start),
  .o_valid     (o_valid)
);

/* design/box_thresh_top.sv */
`timescale 1ns/1ps

module box_thresh_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_col_valid,
  input  logic               i_row_start,
  input  box_pkg::column_t   i_column,
  input  box_pkg::pixel_t    i_offset,
  output logic               o_valid,
  output logic               o_bin,
  output box_pkg::box_sum_t  o_box_sum,
  output box_pkg::pixel_t    o_center
);

  import box_pkg::*;

  logic      tag_valid;
  ctrl_tag_t tag;
  col_data_t col;
  logic      full_valid;
  box_sum_t  box_sum;
  pixel_t    center;

  window_ctrl i_window_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_col_valid (i_col_valid),
    .i_row_start (i_row_start),
    .o_tag_valid (tag_valid),
    .o_tag       (tag)
  );

  col_adder_tree i_col_adder_tree (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_col_valid (i_col_valid),
    .i_column    (i_column),
    .i_tag_valid (tag_valid),
    .i_tag       (tag),
    .o_col       (col)
  );

  box_accum i_box_accum (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_col        (col),
    .o_full_valid (full_valid),
    .o_box_sum    (box_sum),
    .o_center     (center)
  );

  threshold_cmp i_threshold_cmp (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_full_valid (full_valid),
    .i_box_sum    (box_sum),
    .i_center     (center),
    .i_offset     (i_offset),
    .o_valid      (o_valid),
    .o_bin        (o_bin),
    .o_box_sum    (o_box_sum),
    .o_center     (o_center)
  );

endmodule

/* design/threshold_cmp.sv */
`timescale 1ns/1ps

module threshold_cmp (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_full_valid,
  input  box_pkg::box_sum_t  i_box_sum,
  input  box_pkg::pixel_t    i_center,
  input  box_pkg::pixel_t    i_offset,
  output logic               o_valid,
  output logic               o_bin,
  output box_pkg::box_sum_t  o_box_sum,
  output box_pkg::pixel_t    o_center
);

  import box_pkg::*;

  cmp_t center_scaled;
  cmp_t limit_scaled;

  // center > sum / AREA + offset, scaled by AREA on both sides.
  always_comb begin
    center_scaled = cmp_t'(i_center) * cmp_t'(AREA);
    limit_scaled  = cmp_t'(i_box_sum) + cmp_t'(i_offset) * cmp_t'(AREA);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_valid   <= 1'b0;
      o_bin     <= 1'b0;
      o_box_sum <= '0;
      o_center  <= '0;
    end else begin
      o_valid   <= i_full_valid;
      o_bin     <= (center_scaled > limit_scaled);
      o_box_sum <= i_box_sum;
      o_center  <= i_center;
    end
  end

endmodule

/* design/box_accum.sv */
`timescale 1ns/1ps

module box_accum (
  input  logic                clk,
  input  logic                rst_n,
  input  box_pkg::col_data_t  i_col,
  output logic                o_full_valid,
  output box_pkg::box_sum_t   o_box_sum,
  output box_pkg::pixel_t     o_center
);

  import box_pkg::*;

  col_sum_t col_hist [WIN];         // newest column sum at index 0.
  pixel_t   ctr_hist [CENTER_LAG];  // only the center lag is ever read back.
  box_sum_t box_sum_q;
  box_sum_t leaving;
  box_sum_t sum_next;

  // ##############################
  // running sum update
  // ##############################

  always_comb begin
    // with 13 columns held, the last entry is the one dropping out.
    if (i_col.tag.sub_en) begin
      leaving = box_sum_t'(col_hist[WIN-1]);
    end else begin
      leaving = '0;
    end

    if (i_col.tag.ld) begin
      sum_next = box_sum_t'(i_col.col_sum);  // a new row starts from this column.
    end else begin
      sum_next = box_sum_q + box_sum_t'(i_col.col_sum) - leaving;
    end
  end

  // ##############################
  // column histories
  // ##############################

  always_ff @(posedge clk) begin
    if (i_col.valid) begin
      col_hist[0] <= i_col.col_sum;
      for (int k = 1; k < WIN; k++) begin
        col_hist[k] <= col_hist[k-1];
      end
      ctr_hist[0] <= i_col.center;
      for (int k = 1; k < CENTER_LAG; k++) begin
        ctr_hist[k] <= ctr_hist[k-1];
      end
    end
  end

  // ##############################
  // outputs
  // ##############################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      box_sum_q    <= '0;
      o_full_valid <= 1'b0;
      o_center     <= '0;
    end else begin
      o_full_valid <= i_col.valid & i_col.tag.full;
      if (i_col.valid) begin
        box_sum_q <= sum_next;
        o_center  <= ctr_hist[CENTER_LAG-1];  // center sits six columns back.
      end
    end
  end

  assign o_box_sum = box_sum_q;

endmodule

/* design/col_adder_tree.sv */
`timescale 1ns/1ps

module col_adder_tree (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_col_valid,
  input  box_pkg::column_t    i_column,
  input  logic                i_tag_valid,
  input  box_pkg::ctrl_tag_t  i_tag,
  output box_pkg::col_data_t  o_col
);

  import box_pkg::*;

  // the tree below is laid out for a 13-pixel column.
  column_t    col_q;            // input register, same edge as the tag.
  logic [8:0] l1_sum [6];       // pairwise sums of pixels 0..11.
  pixel_t     l1_last;          // pixel 12 waits one level.
  logic [9:0] l2_sum [3];
  pixel_t     l2_last;
  logic [10:0] l3_sum [2];
  col_sum_t   l4_sum;

  // side band, one entry per tree level.
  logic [3:0] vld_q;
  ctrl_tag_t  tag_q [4];
  pixel_t     ctr_q [4];

  // ##############################
  // adder levels
  // ##############################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q   <= '0;
      l1_last <= '0;
      l2_last <= '0;
      l4_sum  <= '0;
      for (int k = 0; k < 6; k++) l1_sum[k] <= '0;
      for (int k = 0; k < 3; k++) l2_sum[k] <= '0;
      l3_sum[0] <= '0;
      l3_sum[1] <= '0;
    end else begin
      if (i_col_valid) col_q <= i_column;  // hold the last column between strobes.

      for (int k = 0; k < 6; k++) begin
        l1_sum[k] <= 9'(col_q[2*k]) + 9'(col_q[2*k+1]);
      end
      l1_last <= col_q[WIN-1];

      for (int k = 0; k < 3; k++) begin
        l2_sum[k] <= 10'(l1_sum[2*k]) + 10'(l1_sum[2*k+1]);
      end
      l2_last <= l1_last;

      l3_sum[0] <= 11'(l2_sum[0]) + 11'(l2_sum[1]);
      l3_sum[1] <= 11'(l2_sum[2]) + 11'(l2_last);

      l4_sum <= col_sum_t'(l3_sum[0]) + col_sum_t'(l3_sum[1]);
    end
  end

  // ##############################
  // tag and center delay line
  // ##############################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
      for (int k = 0; k < 4; k++) begin
        tag_q[k] <= '0;
        ctr_q[k] <= '0;
      end
    end else begin
      vld_q    <= {vld_q[2:0], i_tag_valid};
      tag_q[0] <= i_tag;
      ctr_q[0] <= col_q[CENTER_ROW];
      for (int k = 1; k < 4; k++) begin
        tag_q[k] <= tag_q[k-1];
        ctr_q[k] <= ctr_q[k-1];
      end
    end
  end

  assign o_col = '{valid: vld_q[3], tag: tag_q[3], col_sum: l4_sum, center: ctr_q[3]};

endmodule

/* design/window_ctrl.sv */
`timescale 1ns/1ps

module window_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_col_valid,
  input  logic                i_row_start,
  output logic                o_tag_valid,
  output box_pkg::ctrl_tag_t  o_tag
);

  import box_pkg::*;

  col_cnt_t  cnt_q;    // columns seen in this row, saturates at WIN.
  col_cnt_t  col_idx;  // position of the incoming column, 1-based.
  ctrl_tag_t tag_d;

  // ##############################
  // tag decode
  // ##############################

  always_comb begin
    if (i_row_start) begin
      col_idx = col_cnt_t'(1);
    end else begin
      col_idx = cnt_q + col_cnt_t'(1);
    end

    tag_d.ld     = i_row_start;
    tag_d.full   = (col_idx >= col_cnt_t'(WIN));
    tag_d.sub_en = (col_idx > col_cnt_t'(WIN));  // never on a row start.
  end

  // ##############################
  // column counter and tag register
  // ##############################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q       <= '0;
      o_tag_valid <= 1'b0;
      o_tag       <= '0;
    end else begin
      o_tag_valid <= i_col_valid;
      o_tag       <= tag_d;
      if (i_col_valid) begin
        // once past WIN the count stays at WIN.
        if (tag_d.sub_en) begin
          cnt_q <= col_cnt_t'(WIN);
        end else begin
          cnt_q <= col_idx;
        end
      end
    end
  end

endmodule

/* design/box_pkg.sv */
package box_pkg;

  // ##############################
  // window geometry
  // ##############################

  localparam int WIN        = 13;
  localparam int CENTER_ROW = 6;   // middle pixel of a column.
  localparam int CENTER_LAG = 6;   // columns between the newest one and the center.
  localparam int AREA       = WIN * WIN;

  // column counter, large enough to hold WIN + 1.
  localparam int CNT_W = 4;

  // center * AREA against box sum + offset * AREA.
  localparam int CMP_W = 17;

  // ##############################
  // vector types
  // ##############################

  typedef logic [7:0]       pixel_t;
  typedef logic [11:0]      col_sum_t;   // up to 13 * 255.
  typedef logic [15:0]      box_sum_t;   // up to 169 * 255.
  typedef logic [CNT_W-1:0] col_cnt_t;
  typedef logic [CMP_W-1:0] cmp_t;

  typedef pixel_t [WIN-1:0] column_t;

  // ##############################
  // pipeline structs
  // ##############################

  typedef struct packed {
    logic ld;       // first column of a row.
    logic sub_en;   // the oldest column leaves the window.
    logic full;     // this column completes a window.
  } ctrl_tag_t;

  typedef struct packed {
    logic      valid;
    ctrl_tag_t tag;
    col_sum_t  col_sum;
    pixel_t    center;
  } col_data_t;

endpackage
